//--- src/csidhParamsPkg.sv
package csidhParamsPkg;

	// number of small odd primes in the class group action
	localparam int NumPrimesDef = 130;

	// every small prime fits in twelve bits
	localparam int PrimeWidth = 12;

	// sign bit plus three magnitude bits
	localparam int ExpWidth = 4;

	// room for 4 times the product of all small primes
	localparam int CofWidth = 1088;

	// primes handled per round
	localparam int BatchSizeDef = 16;

	// prime i sits at bits [PrimeWidth*i +: PrimeWidth], highest index first below
	localparam logic [NumPrimesDef*PrimeWidth-1:0] PrimeTable = {
		12'd983, 12'd733, 12'd727, 12'd719, 12'd709,
		12'd701, 12'd691, 12'd683, 12'd677, 12'd673,
		12'd661, 12'd659, 12'd653, 12'd647, 12'd643,
		12'd641, 12'd631, 12'd619, 12'd617, 12'd613,
		12'd607, 12'd601, 12'd599, 12'd593, 12'd587,
		12'd577, 12'd571, 12'd569, 12'd563, 12'd557,
		12'd547, 12'd541, 12'd523, 12'd521, 12'd509,
		12'd503, 12'd499, 12'd491, 12'd487, 12'd479,
		12'd467, 12'd463, 12'd461, 12'd457, 12'd449,
		12'd443, 12'd439, 12'd433, 12'd431, 12'd421,
		12'd419, 12'd409, 12'd401, 12'd397, 12'd389,
		12'd383, 12'd379, 12'd373, 12'd367, 12'd359,
		12'd353, 12'd349, 12'd347, 12'd337, 12'd331,
		12'd317, 12'd313, 12'd311, 12'd307, 12'd293,
		12'd283, 12'd281, 12'd277, 12'd271, 12'd269,
		12'd263, 12'd257, 12'd251, 12'd241, 12'd239,
		12'd233, 12'd229, 12'd227, 12'd223, 12'd211,
		12'd199, 12'd197, 12'd193, 12'd191, 12'd181,
		12'd179, 12'd173, 12'd167, 12'd163, 12'd157,
		12'd151, 12'd149, 12'd139, 12'd137, 12'd131,
		12'd127, 12'd113, 12'd109, 12'd107, 12'd103,
		12'd101, 12'd97,  12'd89,  12'd83,  12'd79,
		12'd73,  12'd71,  12'd67,  12'd61,  12'd59,
		12'd53,  12'd47,  12'd43,  12'd41,  12'd37,
		12'd31,  12'd29,  12'd23,  12'd19,  12'd17,
		12'd13,  12'd11,  12'd7,   12'd5,   12'd3
	};

endpackage

//--- src/csidhTypesPkg.sv
package csidhTypesPkg;

	// one key nibble; sign set means the twist direction
	typedef struct packed {
		logic sign;
		logic [csidhParamsPkg::ExpWidth-2:0] mag;
	} exponent_t;

	// operands for one cofactor step
	typedef struct packed {
		logic [csidhParamsPkg::CofWidth-1:0] cofactor;
		logic [csidhParamsPkg::PrimeWidth-1:0] prime;
	} mulReq_t;

	// one scheduled batch
	// bit i of mask selects prime index i
	typedef struct packed {
		logic dir;
		logic [csidhParamsPkg::NumPrimesDef-1:0] mask;
		logic [csidhParamsPkg::CofWidth-1:0] cofactor;
	} batchDesc_t;

endpackage

//--- src/exponentDecoder.sv
`timescale 1ns/1ps

module exponentDecoder #(
	parameter int NumPrimes = csidhParamsPkg::NumPrimesDef,
	parameter int BatchSize = csidhParamsPkg::BatchSizeDef
) (
	input  logic clk,
	input  logic rst,
	input  logic startReq,
	output logic startAck,
	input  logic [NumPrimes*csidhParamsPkg::ExpWidth-1:0] privateKey,
	output logic mulReq,
	output csidhTypesPkg::mulReq_t mulOperand,
	input  logic mulAck,
	input  logic [csidhParamsPkg::CofWidth-1:0] product,
	output logic descReq,
	output csidhTypesPkg::batchDesc_t desc,
	input  logic descAck,
	output logic scheduleBegin,
	output logic scheduleEnd
);
	import csidhParamsPkg::*;
	import csidhTypesPkg::*;

	localparam int IdxWidth = $clog2(NumPrimes + 1);

	localparam logic [2:0] stIdle = 3'd0;
	localparam logic [2:0] stScan = 3'd1;
	localparam logic [2:0] stMul = 3'd2;
	localparam logic [2:0] stOffer = 3'd3;
	localparam logic [2:0] stDec = 3'd4;

	logic [2:0] state;
	exponent_t exps [NumPrimes];
	logic [IdxWidth-1:0] idx;
	logic [IdxWidth-1:0] batchCnt;
	logic [NumPrimesDef-1:0] mask;
	logic [CofWidth-1:0] cof;
	logic dir;
	logic flipped;

	assign desc = '{dir: dir, mask: mask, cofactor: cof};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			startAck <= 1'b0;
			mulReq <= 1'b0;
			descReq <= 1'b0;
			scheduleBegin <= 1'b0;
			scheduleEnd <= 1'b0;
			idx <= '0;
			batchCnt <= '0;
			mask <= '0;
			dir <= 1'b0;
			flipped <= 1'b0;
		end else begin
			scheduleBegin <= 1'b0;
			scheduleEnd <= 1'b0;
			if (startAck && !startReq)
				startAck <= 1'b0;
			case (state)
				stIdle: begin
					if (startReq && !startAck) begin
						startAck <= 1'b1;
						scheduleBegin <= 1'b1;
						// exponent 0 is the top nibble of the key
						for (int i = 0; i < NumPrimes; i++)
							exps[i] <= privateKey[ExpWidth*(NumPrimes-1-i) +: ExpWidth];
						dir <= 1'b0;
						flipped <= 1'b0;
						idx <= '0;
						batchCnt <= '0;
						mask <= '0;
						state <= stScan;
					end
				end
				stScan: begin
					if (batchCnt == BatchSize || idx == NumPrimes) begin
						idx <= '0;
						if (batchCnt != 0) begin
							flipped <= 1'b0;
							cof <= CofWidth'(4);
							state <= stMul;
						end else if (!flipped) begin
							// nothing left this way, retry the other direction
							dir <= !dir;
							flipped <= 1'b1;
						end else begin
							scheduleEnd <= 1'b1;
							state <= stIdle;
						end
					end else begin
						if (exps[idx].sign == dir && exps[idx].mag != '0) begin
							mask[idx] <= 1'b1;
							batchCnt <= batchCnt + 1'b1;
						end
						idx <= idx + 1'b1;
					end
				end
				stMul: begin
					// cofactor picks up every prime outside the batch
					if (mulReq) begin
						if (mulAck) begin
							cof <= product;
							mulReq <= 1'b0;
							idx <= idx + 1'b1;
						end
					end else if (idx == NumPrimes) begin
						state <= stOffer;
					end else if (mask[idx]) begin
						idx <= idx + 1'b1;
					end else if (!mulAck) begin
						mulOperand <= '{cofactor: cof,
							prime: PrimeTable[idx*PrimeWidth +: PrimeWidth]};
						mulReq <= 1'b1;
					end
				end
				stOffer: begin
					if (!descReq && !descAck) begin
						descReq <= 1'b1;
					end else if (descReq && descAck) begin
						descReq <= 1'b0;
						state <= stDec;
					end
				end
				stDec: begin
					// every selected prime counts as processed
					for (int i = 0; i < NumPrimes; i++)
						if (mask[i])
							exps[i].mag <= exps[i].mag - 1'b1;
					mask <= '0;
					batchCnt <= '0;
					idx <= '0;
					state <= stScan;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

//--- src/cofactorMultiplier.sv
`timescale 1ns/1ps

module cofactorMultiplier (
	input  logic clk,
	input  logic rst,
	input  logic mulReq,
	input  csidhTypesPkg::mulReq_t mulOperand,
	output logic mulAck,
	output logic [csidhParamsPkg::CofWidth-1:0] product
);
	import csidhParamsPkg::*;

	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stShift = 2'd1;
	localparam logic [1:0] stHold = 2'd2;

	logic [1:0] state;
	logic [$clog2(PrimeWidth)-1:0] bitCnt;
	logic [CofWidth-1:0] acc;
	logic [CofWidth-1:0] mcand;
	logic [PrimeWidth-1:0] mplier;

	assign product = acc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			mulAck <= 1'b0;
			bitCnt <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (mulReq) begin
						acc <= '0;
						mcand <= mulOperand.cofactor;
						mplier <= mulOperand.prime;
						bitCnt <= '0;
						state <= stShift;
					end
				end
				stShift: begin
					// lsb first, one prime bit per cycle
					if (mplier[0])
						acc <= acc + mcand;
					mcand <= mcand << 1;
					mplier <= mplier >> 1;
					bitCnt <= bitCnt + 1'b1;
					if (bitCnt == PrimeWidth - 1)
						state <= stHold;
				end
				stHold: begin
					// product stays put until the request is withdrawn
					if (!mulAck) begin
						mulAck <= 1'b1;
					end else if (!mulReq) begin
						mulAck <= 1'b0;
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

//--- src/batchResult.sv
`timescale 1ns/1ps

module batchResult (
	input  logic clk,
	input  logic rst,
	input  logic descReq,
	input  csidhTypesPkg::batchDesc_t desc,
	output logic descAck,
	input  logic scheduleBegin,
	input  logic scheduleEnd,
	output logic batchReq,
	output csidhTypesPkg::batchDesc_t batchOut,
	input  logic batchAck,
	output logic done,
	output logic [7:0] batchCount
);
	import csidhTypesPkg::*;

	batchDesc_t slot;
	logic slotFull;
	logic waitAckLow;
	logic endSeen;

	assign batchOut = slot;

	always_ff @(posedge clk) begin
		if (rst) begin
			descAck <= 1'b0;
			slotFull <= 1'b0;
			batchReq <= 1'b0;
			waitAckLow <= 1'b0;
			endSeen <= 1'b0;
			done <= 1'b0;
			batchCount <= '0;
		end else begin
			// accept from the decoder only into an empty slot
			if (!descAck && descReq && !slotFull) begin
				descAck <= 1'b1;
				slot <= desc;
				slotFull <= 1'b1;
			end else if (descAck && !descReq) begin
				descAck <= 1'b0;
			end

			// outgoing transfer, slot frees once batchAck is back low
			if (slotFull && !batchReq && !waitAckLow) begin
				batchReq <= 1'b1;
			end else if (batchReq && batchAck) begin
				batchReq <= 1'b0;
				waitAckLow <= 1'b1;
			end else if (waitAckLow && !batchAck) begin
				waitAckLow <= 1'b0;
				slotFull <= 1'b0;
				batchCount <= batchCount + 1'b1;
			end

			if (scheduleBegin) begin
				done <= 1'b0;
				endSeen <= 1'b0;
				batchCount <= '0;
			end else begin
				if (scheduleEnd)
					endSeen <= 1'b1;
				if (endSeen && !slotFull)
					done <= 1'b1;
			end
		end
	end

endmodule

//--- src/batchScheduler.sv
`timescale 1ns/1ps

module batchScheduler #(
	parameter int NumPrimes = csidhParamsPkg::NumPrimesDef,
	parameter int BatchSize = csidhParamsPkg::BatchSizeDef
) (
	input  logic clk,
	input  logic rst,
	input  logic startReq,
	output logic startAck,
	input  logic [NumPrimes*csidhParamsPkg::ExpWidth-1:0] privateKey,
	output logic batchReq,
	output csidhTypesPkg::batchDesc_t batchOut,
	input  logic batchAck,
	output logic done,
	output logic [7:0] batchCount
);
	import csidhParamsPkg::*;
	import csidhTypesPkg::*;

	logic mulReq;
	mulReq_t mulOperand;
	logic mulAck;
	logic [CofWidth-1:0] product;
	logic descReq;
	batchDesc_t desc;
	logic descAck;
	logic scheduleBegin;
	logic scheduleEnd;

	exponentDecoder #(
		.NumPrimes(NumPrimes),
		.BatchSize(BatchSize)
	) u_exponentDecoder (
		.clk(clk),
		.rst(rst),
		.startReq(startReq),
		.startAck(startAck),
		.privateKey(privateKey),
		.mulReq(mulReq),
		.mulOperand(mulOperand),
		.mulAck(mulAck),
		.product(product),
		.descReq(descReq),
		.desc(desc),
		.descAck(descAck),
		.scheduleBegin(scheduleBegin),
		.scheduleEnd(scheduleEnd)
	);

	cofactorMultiplier u_cofactorMultiplier (
		.clk(clk),
		.rst(rst),
		.mulReq(mulReq),
		.mulOperand(mulOperand),
		.mulAck(mulAck),
		.product(product)
	);

	batchResult u_batchResult (
		.clk(clk),
		.rst(rst),
		.descReq(descReq),
		.desc(desc),
		.descAck(descAck),
		.scheduleBegin(scheduleBegin),
		.scheduleEnd(scheduleEnd),
		.batchReq(batchReq),
		.batchOut(batchOut),
		.batchAck(batchAck),
		.done(done),
		.batchCount(batchCount)
	);

endmodule

//--- testbench/batchScheduler_props.sv
`timescale 1ns/1ps

module batchScheduler_props (
	input logic clk,
	input logic rst,
	input logic startReq,
	input logic startAck,
	input logic batchReq,
	input csidhTypesPkg::batchDesc_t batchOut,
	input logic batchAck,
	input logic done
);

	// number of failed assertions
	int failCount = 0;

	// request holds until the consumer answers
	reqHeld: assert property (@(posedge clk) disable iff (rst)
		batchReq && !batchAck |=> batchReq)
		else begin
			failCount++;
			$error("batchReq fell before batchAck was seen");
		end

	// descriptor frozen for the whole transfer
	outStable: assert property (@(posedge clk) disable iff (rst)
		batchReq |=> !batchReq || $stable(batchOut))
		else begin
			failCount++;
			$error("batchOut changed while batchReq was high");
		end

	doneExclusive: assert property (@(posedge clk) disable iff (rst)
		!(done && batchReq))
		else begin
			failCount++;
			$error("done and batchReq were high together");
		end

	// start is only acknowledged when requested
	startAckCause: assert property (@(posedge clk) disable iff (rst)
		$rose(startAck) |-> $past(startReq))
		else begin
			failCount++;
			$error("startAck rose without startReq");
		end

endmodule

bind batchScheduler batchScheduler_props u_props (
	.clk(clk),
	.rst(rst),
	.startReq(startReq),
	.startAck(startAck),
	.batchReq(batchReq),
	.batchOut(batchOut),
	.batchAck(batchAck),
	.done(done)
);

//--- testbench/tbBatchScheduler.sv
`timescale 1ns/1ps

module tbBatchScheduler;
	import csidhParamsPkg::*;
	import csidhTypesPkg::*;

	localparam int NumPrimes = NumPrimesDef;
	localparam int BatchSize = BatchSizeDef;
	localparam int KeyWidth = NumPrimes * ExpWidth;
	localparam int NumRows = 5;

	logic clk;
	logic rst;
	logic startReq;
	logic startAck;
	logic [KeyWidth-1:0] privateKey;
	logic batchReq;
	batchDesc_t batchOut;
	logic batchAck;
	logic done;
	logic [7:0] batchCount;

	// stimulus table with one entry per test
	string rowName [NumRows];
	logic [KeyWidth-1:0] rowKey [NumRows];
	logic [7:0] rowCount [NumRows];

	int primeOf [NumPrimes];
	batchDesc_t expQ [$];
	integer seed;
	bit tableReady;

	batchScheduler #(
		.NumPrimes(NumPrimes),
		.BatchSize(BatchSize)
	) u_batchScheduler (
		.clk(clk),
		.rst(rst),
		.startReq(startReq),
		.startAck(startAck),
		.privateKey(privateKey),
		.batchReq(batchReq),
		.batchOut(batchOut),
		.batchAck(batchAck),
		.done(done),
		.batchCount(batchCount)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// odd primes by trial division
	// the last slot holds the large prime
	task automatic buildPrimes();
		int cand;
		bit isPrime;
		cand = 3;
		for (int n = 0; n < NumPrimes; n++) begin
			if (n == NumPrimesDef - 1) begin
				primeOf[n] = 983;
			end else begin
				isPrime = 1'b0;
				while (!isPrime) begin
					isPrime = 1'b1;
					for (int d = 3; d * d <= cand; d += 2)
						if (cand % d == 0)
							isPrime = 1'b0;
					if (isPrime)
						primeOf[n] = cand;
					cand += 2;
				end
			end
		end
	endtask

	function automatic logic [KeyWidth-1:0] withExp(input logic [KeyWidth-1:0] key,
			input int idx, input logic [ExpWidth-1:0] val);
		logic [KeyWidth-1:0] k;
		k = key;
		// exponent 0 lives in the top nibble
		k[ExpWidth*(NumPrimes-1-idx) +: ExpWidth] = val;
		return k;
	endfunction

	function automatic logic [CofWidth-1:0] cofactorFor(input logic [NumPrimesDef-1:0] mask);
		logic [CofWidth-1:0] c;
		c = CofWidth'(4);
		for (int i = 0; i < NumPrimes; i++)
			if (!mask[i])
				c = c * CofWidth'(primeOf[i]);
		return c;
	endfunction

	// reference schedule filling expQ with every descriptor in order
	task automatic buildExpected(input logic [KeyWidth-1:0] key);
		logic sgn [NumPrimes];
		int mag [NumPrimes];
		logic dir;
		int picked;
		bit finished;
		batchDesc_t d;
		expQ.delete();
		for (int i = 0; i < NumPrimes; i++) begin
			sgn[i] = key[ExpWidth*(NumPrimes-1-i) + ExpWidth-1];
			mag[i] = key[ExpWidth*(NumPrimes-1-i) +: ExpWidth-1];
		end
		dir = 1'b0;
		finished = 1'b0;
		while (!finished) begin
			d = '0;
			picked = 0;
			for (int flip = 0; flip < 2 && picked == 0; flip++) begin
				if (flip == 1)
					dir = !dir;
				for (int i = 0; i < NumPrimes && picked < BatchSize; i++)
					if (sgn[i] == dir && mag[i] != 0) begin
						d.mask[i] = 1'b1;
						picked++;
					end
			end
			if (picked == 0) begin
				finished = 1'b1;
			end else begin
				d.dir = dir;
				d.cofactor = cofactorFor(d.mask);
				expQ.push_back(d);
				for (int i = 0; i < NumPrimes; i++)
					if (d.mask[i])
						mag[i]--;
			end
		end
	endtask

	task automatic fillTable();
		logic [KeyWidth-1:0] key;
		logic [31:0] rnd;
		int mag;
		rowName[0] = "zeroKey";
		rowKey[0] = '0;
		rowCount[0] = 8'd0;
		rowName[1] = "singlePlusOne";
		rowKey[1] = withExp('0, 5, 4'b0001);
		rowCount[1] = 8'd1;
		rowName[2] = "singleMinusThree";
		rowKey[2] = withExp('0, 7, 4'b1011);
		rowCount[2] = 8'd3;
		key = '0;
		for (int i = 0; i < 20; i++)
			key = withExp(key, i, 4'b0001);
		rowName[3] = "twentyPlusOne";
		rowKey[3] = key;
		rowCount[3] = 8'd2;
		// mixed signs with magnitudes 0 to 2
		key = '0;
		for (int i = 0; i < NumPrimes; i++) begin
			rnd = $random(seed);
			mag = rnd % 3;
			key = withExp(key, i, {rnd[31], 3'(mag)});
		end
		rowName[4] = "randomMixed";
		rowKey[4] = key;
		buildExpected(key);
		rowCount[4] = 8'(expQ.size());
	endtask

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run aborted");
	endtask

	function automatic string formatDesc(input batchDesc_t d);
		return $sformatf("dir %0b mask %h cofactor %h", d.dir, d.mask, d.cofactor);
	endfunction

	task automatic compareDesc(input string name, input batchDesc_t expected,
			input batchDesc_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %s, actual %s",
				name, formatDesc(expected), formatDesc(actual));
			$display("TEST RESULT: FAIL");
			$fatal(1, "descriptor mismatch");
		end
	endtask

	task automatic compareCount(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected count %0d, actual count %0d",
				name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "count mismatch");
		end
	endtask

	// the bound checker counts its failed handshake assertions
	initial begin : assertionWatch
		wait (u_batchScheduler.u_props.failCount != 0);
		abortRun("a handshake assertion in the bound checker failed");
	end

	initial begin : watchdog
		int limit;
		wait (tableReady);
		limit = 10;
		for (int r = 0; r < NumRows; r++)
			limit += rowCount[r] * NumPrimes * 20 + 2000;
		repeat (limit) @(posedge clk);
		$display("Run did not finish within %0d cycles, the DUT appears to hang", limit);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin : mainFlow
		int delay;
		int got;
		bit finished;
		batchDesc_t act;
		rst = 1'b1;
		startReq = 1'b0;
		privateKey = '0;
		batchAck = 1'b0;
		seed = 32'h4203_f7fa;
		tableReady = 1'b0;
		buildPrimes();
		fillTable();
		tableReady = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		for (int r = 0; r < NumRows; r++) begin
			buildExpected(rowKey[r]);
			@(posedge clk);
			privateKey <= rowKey[r];
			startReq <= 1'b1;
			do @(posedge clk); while (!startAck);
			startReq <= 1'b0;
			do @(posedge clk); while (startAck);
			got = 0;
			finished = 1'b0;
			while (!finished) begin
				@(posedge clk);
				if (done) begin
					finished = 1'b1;
				end else if (batchReq) begin
					act = batchOut;
					if (expQ.size() == 0)
						abortRun($sformatf("%s: DUT sent more batches than expected",
							rowName[r]));
					compareDesc(rowName[r], expQ.pop_front(), act);
					got++;
					// random back-pressure before answering
					delay = $unsigned($random(seed)) % 6;
					repeat (delay) @(posedge clk);
					batchAck <= 1'b1;
					do @(posedge clk); while (batchReq);
					batchAck <= 1'b0;
				end
			end
			if (expQ.size() != 0)
				abortRun($sformatf("%s: done rose with %0d batches still missing",
					rowName[r], expQ.size()));
			compareCount(rowName[r], rowCount[r], 8'(got));
			compareCount(rowName[r], rowCount[r], batchCount);
			$display("row %s finished with %0d batches", rowName[r], got);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- src.f
src/csidhParamsPkg.sv
src/csidhTypesPkg.sv
src/exponentDecoder.sv
src/cofactorMultiplier.sv
src/batchResult.sv
src/batchScheduler.sv
testbench/batchScheduler_props.sv
testbench/tbBatchScheduler.sv
